//--- verif/blur_patterns.mem
// per frame: 8 input rows, then 8 expected blurred rows
// each line is one image row, 8 hex pixels from left to right
0a 28 05 46 14 5a 00 21
23 41 1e 5f 2d 73 19 3a
46 64 41 82 50 96 3c 5d
19 37 14 55 23 69 0f 30
6e 8c 69 aa 78 be 64 85
0d 2b 08 49 17 5d 03 24
3c 5a 37 78 46 8c 32 53
5a 78 55 96 64 aa 50 71
17 1e 24 2f 38 38 25 1f
2d 33 39 44 4d 4d 3a 34
39 3f 46 51 5a 5a 46 40
41 47 4d 58 61 61 4e 48
48 4e 54 5f 68 68 55 4f
38 3e 45 50 59 59 45 3f
3f 45 4b 57 5f 5f 4c 46
5a 60 66 71 7a 7a 67 61
ff ff ff ff ff ff ff ff
ff 14 14 14 14 14 14 ff
ff 14 14 14 14 14 14 ff
ff 14 14 14 14 14 14 ff
ff 14 14 14 14 14 14 ff
ff 14 14 14 14 14 14 ff
ff 14 14 14 14 14 14 ff
ff ff ff ff ff ff ff ff
f0 d2 c4 c4 c4 c4 d2 f0
d2 7a 4e 4e 4e 4e 7a d2
c4 4e 14 14 14 14 4e c4
c4 4e 14 14 14 14 4e c4
c4 4e 14 14 14 14 4e c4
c4 4e 14 14 14 14 4e c4
d2 7a 4e 4e 4e 4e 7a d2
f0 d2 c4 c4 c4 c4 d2 f0

//--- tb.f
rtl/img_pkg.sv
rtl/blur_pkg.sv
rtl/fb_if.sv
rtl/frame_buffer.sv
rtl/pixel_loader.sv
rtl/blur_img.sv
rtl/gaussian_3x3.sv
rtl/pixel_unloader.sv
rtl/blur_top.sv
verif/blur_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= blur_tb
BUILD_DIR ?= build
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timescale 1ns/1ps -j 0

SIM_BIN = $(BUILD_DIR)/$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

# the simulation passes only if its output holds the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/blur_tb.sv
`timescale 1ns/1ps

module blur_tb;
    import img_pkg::*;

    localparam int          N_FRAMES       = 2;
    localparam int          PAT_WORDS      = N_FRAMES * 2 * NPIX;  // input and expected per frame
    localparam int          PAT_AW         = $clog2(PAT_WORDS);
    localparam int          MAX_GAP        = 5;
    localparam int          DRIVE_DELAY    = 1;
    localparam int unsigned RAND_SEED      = 5348;
    localparam int          TIMEOUT_CYCLES = 2 * NPIX * 60 + 500;

    logic        clk_in;
    logic        rst_in;
    logic        in_req;
    logic        in_ack;
    logic        out_req;
    logic        out_ack;
    pixel_t      in_pixel;
    pixel_t      out_pixel;
    pixel_t      pat_mem [PAT_WORDS];
    int          mismatches      = 0;
    int          other_errors    = 0;
    int          frames_loaded   = 0;
    int          frames_received = 0;
    int          req_rises       = 0;  // out_req rising edges seen by the monitor
    int          cycle_count     = 0;
    logic        in_req_q        = 1'b0;
    logic        in_ack_q        = 1'b0;
    logic        out_req_q       = 1'b0;
    logic        out_ack_q       = 1'b0;
    pixel_t      out_pixel_q     = '0;

    blur_top i_blur_top (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .in_req    (in_req),
        .in_pixel  (in_pixel),
        .in_ack    (in_ack),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_pixel (out_pixel)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic check_pixel(pixel_t got, pixel_t expected, int index);
        if (got !== expected) begin
            mismatches++;
            $display("MISMATCH %0t: pixel %0d got %02h, expected %02h",
                     $time, index, got, expected);
        end
    endtask

    task automatic check_count(pix_addr_t got, pix_addr_t expected);
        if (got !== expected) begin
            mismatches++;
            $display("MISMATCH %0t: received %0d pixels in a frame, expected %0d",
                     $time, got, expected);
        end
    endtask

    task automatic report_protocol_error(string msg);
        other_errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // section 0 is the input frame and section 1 the blurred one
    function automatic pixel_t pattern_word(int frame, int section, int i);
        int idx;
        idx = (frame * 2 + section) * NPIX + i;
        return pat_mem[PAT_AW'(idx)];
    endfunction

    task automatic drive_point();
        @(posedge clk_in);
        #DRIVE_DELAY;
    endtask

    task automatic check_idle_outputs(string when);
        if (in_ack !== 1'b0 || out_req !== 1'b0) begin
            report_protocol_error($sformatf("in_ack or out_req not low %s", when));
        end
    endtask

    task automatic send_pixel(pixel_t value);
        int gap;
        gap = $urandom_range(MAX_GAP, 0);
        repeat (gap) drive_point();
        if (in_ack) begin
            report_protocol_error("in_ack still high when a new request was due");
        end
        in_pixel = value;
        in_req   = 1'b1;
        while (!in_ack) drive_point();
        in_req = 1'b0;
        while (in_ack) drive_point();
    endtask

    task automatic send_frame(int f);
        for (int i = 0; i < NPIX; i++) begin
            send_pixel(pattern_word(f, 0, i));
            if (i == 0 && frames_received < f) begin
                report_protocol_error("new frame accepted before the previous one was sent back");
            end
        end
        frames_loaded++;
    endtask

    task automatic receive_frame(int f);
        int     base;
        int     delay;
        pixel_t got;
        base = req_rises;
        for (int i = 0; i < NPIX; i++) begin
            while (!out_req) drive_point();
            if (i == 0 && frames_loaded <= f) begin
                report_protocol_error("out_req raised before the whole input frame was acknowledged");
            end
            got   = out_pixel;
            delay = $urandom_range(MAX_GAP, 0);
            repeat (delay) drive_point();   // host back-pressure
            out_ack = 1'b1;
            while (out_req) drive_point();
            check_pixel(got, pattern_word(f, 1, i), f * NPIX + i);
            out_ack = 1'b0;
        end
        check_count(pix_addr_t'(req_rises - base), pix_addr_t'(NPIX));
        frames_received++;
    endtask

    task automatic finish_run();
        $display("SUMMARY mismatches=%0d other_errors=%0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // four-phase rules on both ports checked on the falling edge
    always @(negedge clk_in) begin
        if (!rst_in) begin
            if (in_ack && !in_ack_q && !in_req_q) begin
                report_protocol_error("in_ack rose without a pending in_req");
            end
            if (!in_ack && in_ack_q && in_req_q) begin
                report_protocol_error("in_ack fell while in_req was still high");
            end
            if (out_req && !out_req_q && out_ack_q) begin
                report_protocol_error("out_req rose while out_ack was still high");
            end
            if (!out_req && out_req_q && !out_ack_q) begin
                report_protocol_error("out_req fell before out_ack was given");
            end
            if (out_req && out_req_q && out_pixel !== out_pixel_q) begin
                report_protocol_error("out_pixel changed while out_req was high");
            end
            if (out_req && !out_req_q) begin
                req_rises++;
            end
        end
        in_req_q    = in_req;
        in_ack_q    = in_ack;
        out_req_q   = out_req;
        out_ack_q   = out_ack;
        out_pixel_q = out_pixel;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycle_count++;
        end
        report_protocol_error($sformatf("run timed out after %0d cycles", cycle_count));
        finish_run();
    end

    initial begin
        void'($urandom(RAND_SEED));
        rst_in   = 1'b1;
        in_req   = 1'b0;
        in_pixel = '0;
        out_ack  = 1'b0;
        $readmemh("verif/blur_patterns.mem", pat_mem);

        repeat (3) begin
            drive_point();
            check_idle_outputs("during reset");
        end
        rst_in = 1'b0;
        drive_point();
        check_idle_outputs("right after reset");

        fork
            begin : host_send
                for (int f = 0; f < N_FRAMES; f++) send_frame(f);
            end
            begin : host_receive
                for (int f = 0; f < N_FRAMES; f++) receive_frame(f);
            end
        join

        // stray outputs after the last frame would show up here
        repeat (100) drive_point();
        check_count(pix_addr_t'(req_rises - (N_FRAMES - 1) * NPIX), pix_addr_t'(NPIX));
        check_idle_outputs("after the last frame");
        finish_run();
    end

endmodule

//--- rtl/blur_top.sv
`timescale 1ns/1ps

module blur_top (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            in_req,
    input  img_pkg::pixel_t in_pixel,
    output logic            in_ack,
    output logic            out_req,
    input  logic            out_ack,
    output img_pkg::pixel_t out_pixel
);
    import img_pkg::*;
    import blur_pkg::*;

    fb_if src_fb ();    // host frame, loader to blur
    fb_if dst_fb ();    // blurred frame, blur to unloader

    logic    start;
    logic    blur_done;
    logic    frame_sent;
    logic    win_valid;
    logic    res_valid;
    window_t window;
    pixel_t  result;

    frame_buffer i_src_buf (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .mem    (src_fb.memory)
    );

    frame_buffer i_dst_buf (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .mem    (dst_fb.memory)
    );

    pixel_loader i_loader (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .in_req     (in_req),
        .in_pixel   (in_pixel),
        .in_ack     (in_ack),
        .frame_sent (frame_sent),
        .start      (start),
        .wr         (src_fb.writer)
    );

    blur_img i_blur (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .start     (start),
        .rd        (src_fb.reader),
        .wr        (dst_fb.writer),
        .win_valid (win_valid),
        .window    (window),
        .res_valid (res_valid),
        .result    (result),
        .blur_done (blur_done)
    );

    gaussian_3x3 i_kernel (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .win_valid (win_valid),
        .window    (window),
        .res_valid (res_valid),
        .result    (result)
    );

    pixel_unloader i_unloader (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .blur_done  (blur_done),
        .rd         (dst_fb.reader),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_pixel  (out_pixel),
        .frame_sent (frame_sent)
    );

endmodule

//--- rtl/pixel_unloader.sv
`timescale 1ns/1ps

module pixel_unloader (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            blur_done,
    fb_if.reader            rd,
    output logic            out_req,
    input  logic            out_ack,
    output img_pkg::pixel_t out_pixel,
    output logic            frame_sent
);
    import img_pkg::*;

    typedef enum logic [2:0] {
        UL_IDLE,
        UL_READ,
        UL_WAIT,
        UL_DATA,
        UL_REQ,
        UL_ACK
    } unload_state_t;

    unload_state_t state;
    pix_addr_t     out_count;

    assign rd.rd_en   = (state == UL_READ);
    assign rd.rd_addr = out_count;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state      <= UL_IDLE;
            out_count  <= '0;
            out_req    <= 1'b0;
            frame_sent <= 1'b0;
        end else begin
            frame_sent <= 1'b0;
            case (state)
                UL_IDLE: begin
                    if (blur_done) begin
                        out_count <= '0;
                        state     <= UL_READ;
                    end
                end
                UL_READ: state <= UL_WAIT;
                UL_WAIT: state <= UL_DATA;      // rd_data lands next cycle
                UL_DATA: begin
                    out_req <= 1'b1;
                    state   <= UL_REQ;
                end
                UL_REQ: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= UL_ACK;
                    end
                end
                UL_ACK: begin
                    // host must drop ack before the next pixel goes out
                    if (!out_ack) begin
                        if (out_count == pix_addr_t'(NPIX - 1)) begin
                            frame_sent <= 1'b1;
                            state      <= UL_IDLE;
                        end else begin
                            out_count <= out_count + pix_addr_t'(1);
                            state     <= UL_READ;
                        end
                    end
                end
                default: state <= UL_IDLE;
            endcase
        end
    end

    // held from capture until the next pixel, covers the whole req high time
    always_ff @(posedge clk_in) begin
        if (state == UL_DATA) begin
            out_pixel <= rd.rd_data;
        end
    end

endmodule

//--- rtl/gaussian_3x3.sv
`timescale 1ns/1ps

module gaussian_3x3 (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              win_valid,
    input  blur_pkg::window_t window,
    output logic              res_valid,
    output img_pkg::pixel_t   result
);
    import img_pkg::*;
    import blur_pkg::*;

    logic             sum_valid;
    logic [SUM_W-1:0] top_sum;
    logic [SUM_W-1:0] mid_sum;
    logic [SUM_W-1:0] bot_sum;
    logic [SUM_W-1:0] total;

    // one row of the kernel, scaled by the weight of that row
    function automatic logic [SUM_W-1:0] row_sum(win_row_t row, int unsigned row_wt);
        return SUM_W'(row_wt * (KW_SIDE * row.left + KW_MID * row.center
                                + KW_SIDE * row.right));
    endfunction

    assign total = top_sum + mid_sum + bot_sum;     // at most 16 * 255, fits SUM_W

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sum_valid <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            sum_valid <= win_valid;
            res_valid <= sum_valid;
        end
    end

    // stage one row sums, stage two total and normalise
    always_ff @(posedge clk_in) begin
        top_sum <= row_sum(window.top, KW_SIDE);
        mid_sum <= row_sum(window.mid, KW_MID);
        bot_sum <= row_sum(window.bot, KW_SIDE);
        result  <= pixel_t'(total >> KERNEL_SHIFT);    // truncating divide
    end

endmodule

//--- rtl/blur_img.sv
`timescale 1ns/1ps

module blur_img (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              start,
    fb_if.reader              rd,
    fb_if.writer              wr,
    output logic              win_valid,
    output blur_pkg::window_t window,
    input  logic              res_valid,
    input  img_pkg::pixel_t   result,
    output logic              blur_done
);
    import img_pkg::*;
    import blur_pkg::*;

    logic                  busy;
    logic [1:0]            phase;       // one read every 3 cycles
    logic [1:0]            kx;          // neighbour column, 0 is left
    logic [1:0]            ky;          // neighbour row, 0 is above
    logic [3:0]            kidx;
    col_t                  cx;
    row_t                  cy;
    logic                  issue;
    logic                  last_tap;
    logic                  last_center;
    logic [1:0]            rv_pipe;     // read valid, aligned to rd_data
    logic [3:0]            kidx_pipe [2];
    pixel_t [0:WIN_TAPS-1] win_flat;    // tap 0 is top left, the MSB of window
    pix_addr_t             addr_fifo [2];
    logic                  push_ptr;
    logic                  pop_ptr;
    pix_addr_t             head_addr;

    // step one position toward a neighbour, staying inside 0..lim-1
    function automatic int unsigned clamp_tap(int unsigned pos, logic [1:0] k,
                                              int unsigned lim);
        int unsigned n;
        n = pos;
        if (k == 2'd0 && pos != 0) begin
            n = pos - 1;
        end else if (k == 2'd2 && pos != lim - 1) begin
            n = pos + 1;
        end
        return n;
    endfunction

    function automatic pix_addr_t raster(int unsigned y, int unsigned x);
        return pix_addr_t'(y * IMG_W + x);
    endfunction

    assign kidx        = 4'(ky) * 4'd3 + 4'(kx);
    assign issue       = busy && (phase == 2'd0);
    assign last_tap    = (kidx == 4'(WIN_TAPS - 1));
    assign last_center = (cx == col_t'(IMG_W - 1)) && (cy == row_t'(IMG_H - 1));

    assign rd.rd_en   = issue;
    assign rd.rd_addr = raster(clamp_tap(32'(cy), ky, IMG_H), clamp_tap(32'(cx), kx, IMG_W));

    assign window = window_t'(win_flat);

    // results leave the kernel in window order, so the oldest address matches
    assign head_addr  = addr_fifo[pop_ptr];
    assign wr.wr_en   = res_valid;
    assign wr.wr_addr = head_addr;
    assign wr.wr_data = result;

    // center and tap sequencer
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy     <= 1'b0;
            phase    <= '0;
            kx       <= '0;
            ky       <= '0;
            cx       <= '0;
            cy       <= '0;
            push_ptr <= 1'b0;
        end else if (start) begin
            busy  <= 1'b1;
            phase <= '0;
            kx    <= '0;
            ky    <= '0;
            cx    <= '0;
            cy    <= '0;
        end else if (busy) begin
            phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
            if (issue) begin
                if (kx != 2'd2) begin
                    kx <= kx + 2'd1;
                end else begin
                    kx <= '0;
                    ky <= (ky == 2'd2) ? 2'd0 : ky + 2'd1;
                end
                if (last_tap) begin
                    push_ptr <= ~push_ptr;
                    if (last_center) begin
                        busy <= 1'b0;   // last window's reads are out, data still in flight
                    end else if (cx == col_t'(IMG_W - 1)) begin
                        cx <= '0;
                        cy <= cy + row_t'(1);
                    end else begin
                        cx <= cx + col_t'(1);
                    end
                end
            end
        end
    end

    // read return and result tracking
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rv_pipe   <= '0;
            win_valid <= 1'b0;
            pop_ptr   <= 1'b0;
            blur_done <= 1'b0;
        end else begin
            rv_pipe   <= {rv_pipe[0], issue};
            win_valid <= rv_pipe[1] && (kidx_pipe[1] == 4'(WIN_TAPS - 1));
            if (res_valid) begin
                pop_ptr <= ~pop_ptr;
            end
            blur_done <= res_valid && (head_addr == pix_addr_t'(NPIX - 1));
        end
    end

    always_ff @(posedge clk_in) begin
        kidx_pipe[0] <= kidx;
        kidx_pipe[1] <= kidx_pipe[0];
        if (rv_pipe[1]) begin
            win_flat[kidx_pipe[1]] <= rd.rd_data;
        end
        if (issue && last_tap) begin
            addr_fifo[push_ptr] <= raster(32'(cy), 32'(cx));  // queued at the last read
        end
    end

endmodule

//--- rtl/pixel_loader.sv
`timescale 1ns/1ps

module pixel_loader (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            in_req,
    input  img_pkg::pixel_t in_pixel,
    output logic            in_ack,
    input  logic            frame_sent,
    output logic            start,
    fb_if.writer            wr
);
    import img_pkg::*;

    typedef enum logic [1:0] {
        LD_ACCEPT,
        LD_ACK,
        LD_WAIT
    } load_state_t;

    load_state_t state;
    pix_addr_t   wr_count;      // raster position of the next input pixel

    // the pixel lands in the buffer on the same edge that raises in_ack
    assign wr.wr_en   = (state == LD_ACCEPT) && in_req;
    assign wr.wr_addr = wr_count;
    assign wr.wr_data = in_pixel;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state    <= LD_ACCEPT;
            wr_count <= '0;
            in_ack   <= 1'b0;
            start    <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                LD_ACCEPT: begin
                    if (in_req) begin
                        in_ack <= 1'b1;
                        state  <= LD_ACK;
                    end
                end
                LD_ACK: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        if (wr_count == pix_addr_t'(NPIX - 1)) begin
                            state <= LD_WAIT;
                        end else begin
                            wr_count <= wr_count + pix_addr_t'(1);
                            state    <= LD_ACCEPT;
                        end
                    end
                end
                LD_WAIT: begin
                    // first cycle here still holds the last address, so start fires once
                    if (wr_count != '0) begin
                        start    <= 1'b1;
                        wr_count <= '0;
                    end else if (frame_sent) begin
                        state <= LD_ACCEPT;
                    end
                end
                default: state <= LD_ACCEPT;
            endcase
        end
    end

endmodule

//--- rtl/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
    input  logic clk_in,
    input  logic rst_in,
    fb_if.memory mem
);
    import img_pkg::*;

    pixel_t            ram [NPIX];
    logic [RAM_AW-1:0] rd_addr_q;

    // write port and first read stage
    always_ff @(posedge clk_in) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr[RAM_AW-1:0]] <= mem.wr_data;
        end
        if (mem.rd_en) begin
            rd_addr_q <= mem.rd_addr[RAM_AW-1:0];  // address held until the next read
        end
    end

    // output register, second cycle of latency
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            mem.rd_data <= '0;
        end else begin
            mem.rd_data <= ram[rd_addr_q];
        end
    end

endmodule

//--- rtl/fb_if.sv
`timescale 1ns/1ps

interface fb_if;
    import img_pkg::*;

    logic      wr_en;
    pix_addr_t wr_addr;
    pixel_t    wr_data;
    logic      rd_en;
    pix_addr_t rd_addr;
    pixel_t    rd_data;     // two cycles after rd_en

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_en, rd_addr,
        input  rd_data
    );

    modport memory (
        input  wr_en, wr_addr, wr_data,
        input  rd_en, rd_addr,
        output rd_data
    );

endinterface

//--- rtl/blur_pkg.sv
package blur_pkg;

    // kernel is the outer product of [1 2 1] with itself
    localparam int unsigned KW_SIDE = 1;
    localparam int unsigned KW_MID  = 2;

    localparam int KERNEL_SHIFT = 4;                // divide by the kernel sum of 16
    localparam int SUM_W        = img_pkg::PIX_W + 4;
    localparam int WIN_TAPS     = 9;

    typedef struct packed {
        img_pkg::pixel_t left;
        img_pkg::pixel_t center;
        img_pkg::pixel_t right;
    } win_row_t;

    typedef struct packed {
        win_row_t top;
        win_row_t mid;
        win_row_t bot;
    } window_t;

endpackage

//--- rtl/img_pkg.sv
package img_pkg;

    localparam int IMG_W  = 8;              // pixels per row
    localparam int IMG_H  = 8;              // rows per frame
    localparam int PIX_W  = 8;
    localparam int NPIX   = IMG_W * IMG_H;

    // one spare bit so a count can reach NPIX itself
    localparam int ADDR_W = $clog2(NPIX + 1);
    localparam int RAM_AW = $clog2(NPIX);   // index bits of the pixel memory
    localparam int COL_W  = $clog2(IMG_W);
    localparam int ROW_W  = $clog2(IMG_H);

    typedef logic [PIX_W-1:0]  pixel_t;
    typedef logic [ADDR_W-1:0] pix_addr_t;
    typedef logic [COL_W-1:0]  col_t;
    typedef logic [ROW_W-1:0]  row_t;

endpackage
